/* bench/oflow_buffer_props.sv */
/*
 * Concurrent checks on the frame tracker, bound into every tracker instance.
 */
`default_nettype none

module oflow_buffer_props (
	input logic                                       clk,
	input logic                                       reset_N,
	input logic                                       frame_start,
	input logic [oflow_frame_pkg::FRAME_NUM_WIDTH-1:0] frame_num,
	input logic [oflow_frame_pkg::SLOT_WIDTH-1:0]      slot,
	input logic [oflow_frame_pkg::HIST_WIDTH-1:0]      hist_count
);
	timeunit 1ns;
	timeprecision 1ps;

	// --------------------------------------
	// slot and counter
	// --------------------------------------
	slot_in_range: assert property (@(posedge clk) disable iff (!reset_N)
		slot < hist_count)
		else $error("slot %0d not below history count %0d", slot, hist_count);

	frame_step: assert property (@(posedge clk) disable iff (!reset_N)
		frame_start |=> (frame_num == $past(frame_num) + 8'd1))    // wraps at 255
		else $error("frame_num did not advance by one");

	slot_zero_at_frame_zero: assert property (@(posedge clk) disable iff (!reset_N)
		(frame_num == '0) |-> (slot == '0))
		else $error("slot %0d at frame 0", slot);

	// latched n always legal after clamping
	hist_legal: assert property (@(posedge clk) disable iff (!reset_N)
		hist_count >= 1 && hist_count <= oflow_frame_pkg::MAX_HISTORY)
		else $error("history count %0d out of range", hist_count);

endmodule : oflow_buffer_props

bind oflow_frame_tracker oflow_buffer_props props_i (
	.clk         (clk),
	.reset_N     (reset_N),
	.frame_start (frame_start),
	.frame_num   (frame_num),
	.slot        (slot),
	.hist_count  (hist_count)
);

`default_nettype wire

/* bench/oflow_buffer_tb.sv */
/*
 * Directed testbench for the history frame memory top level.
 * Keeps a model of frame, slot, latched n and RAM contents and checks every readback.
 */
`default_nettype none

module oflow_buffer_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DW = oflow_mem_pkg::DATA_WIDTH_DEF;
	localparam int DEPTH = oflow_mem_pkg::MEM_DEPTH_DEF;
	localparam int OW = oflow_mem_pkg::OFFSET_WIDTH_DEF;
	localparam int HW = oflow_frame_pkg::HIST_WIDTH;
	localparam int FW = oflow_frame_pkg::FRAME_NUM_WIDTH;
	localparam int LOOP_LIMIT = 16;    // cycles before a wait gives up

	// --------------------------------------
	// DUT signals
	// --------------------------------------
	logic          clk;
	logic          reset_N;
	logic          frame_start;
	logic [HW-1:0] num_of_history_frames;
	logic          we;
	logic [OW-1:0] offset_0;
	logic [OW-1:0] offset_1;
	logic [DW-1:0] data_in_0;
	logic [DW-1:0] data_in_1;
	logic [FW-1:0] frame_num;
	logic [DW-1:0] data_out_0;
	logic [DW-1:0] data_out_1;

	// reference model state
	logic [DW-1:0] model_mem [DEPTH];
	bit            model_valid [DEPTH];    // only written words are checked
	int            mdl_frame;
	int            mdl_n;                  // latched history count
	int            err_count;
	int            test_err_start;
	int            tests_ok;
	int            tests_bad;

	oflow_buffer_top #(
		.DATA_WIDTH (oflow_mem_pkg::DATA_WIDTH_DEF),
		.MEM_DEPTH  (oflow_mem_pkg::MEM_DEPTH_DEF),
		.ADDR_WIDTH (oflow_mem_pkg::ADDR_WIDTH_DEF)
	) dut_i (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_start           (frame_start),
		.num_of_history_frames (num_of_history_frames),
		.we                    (we),
		.offset_0              (offset_0),
		.offset_1              (offset_1),
		.data_in_0             (data_in_0),
		.data_in_1             (data_in_1),
		.frame_num             (frame_num),
		.data_out_0            (data_out_0),
		.data_out_1            (data_out_1)
	);

	always #10 clk = ~clk;    // 20 ns period

	// --------------------------------------
	// model helpers
	// --------------------------------------
	function automatic int clamp_hist(input int n);
		if (n == 0 || n > oflow_frame_pkg::MAX_HISTORY) begin
			return 1;    // illegal counts fall back to one region
		end
		return n;
	endfunction

	// slot = frame mod n, base = slot * floor(depth / n)
	function automatic int region_addr(input int off);
		int slot;
		slot = mdl_frame % mdl_n;
		return slot * (DEPTH / mdl_n) + off;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;    // drive and sample just after the edge
	endtask

	task automatic check_value(input string name, input logic [DW-1:0] got,
		input logic [DW-1:0] exp);
		if (got !== exp) begin
			$display("FAIL %0d ns %s got %h expected %h", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic finish_test(input string name);
		if (err_count == test_err_start) begin
			$display("%s: ok", name);
			tests_ok++;
		end else begin
			$display("%s: FAILED with %0d errors", name, err_count - test_err_start);
			tests_bad++;
		end
		test_err_start = err_count;
	endtask

	// --------------------------------------
	// bus tasks
	// --------------------------------------
	task automatic apply_reset(input int n);
		int i;
		num_of_history_frames = HW'(n);
		frame_start = 1'b0;
		we = 1'b0;
		reset_N = 1'b0;
		for (i = 0; i < 8; i++) begin
			next_cycle();
		end
		reset_N = 1'b1;
		mdl_frame = 0;
		mdl_n = clamp_hist(n);    // n latched during reset
	endtask

	task automatic advance_frame();
		int            waited;
		logic [FW-1:0] want;
		waited = 0;
		we = 1'b0;
		frame_start = 1'b1;
		next_cycle();
		frame_start = 1'b0;
		mdl_frame = (mdl_frame + 1) % (1 << FW);
		if (mdl_frame == 0) begin
			mdl_n = clamp_hist(num_of_history_frames);    // relatch at wrap only
		end
		want = FW'(mdl_frame);
		while (frame_num !== want && waited < LOOP_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (frame_num !== want) begin
			$display("timeout at %0d ns: frame_num never reached %0d", $time, want);
			err_count++;
		end
	endtask

	task automatic write_pair(input int off0, input int off1,
		input logic [DW-1:0] d0, input logic [DW-1:0] d1);
		int a0;
		int a1;
		a0 = region_addr(off0);
		a1 = region_addr(off1);
		offset_0 = OW'(off0);
		offset_1 = OW'(off1);
		data_in_0 = d0;
		data_in_1 = d1;
		we = 1'b1;
		next_cycle();
		we = 1'b0;
		model_mem[a1] = d1;
		model_valid[a1] = 1'b1;
		model_mem[a0] = d0;    // port 0 wins a collision
		model_valid[a0] = 1'b1;
	endtask

	// one cycle read latency
	task automatic read_pair(input int off0, input int off1);
		int a0;
		int a1;
		a0 = region_addr(off0);
		a1 = region_addr(off1);
		offset_0 = OW'(off0);
		offset_1 = OW'(off1);
		we = 1'b0;
		next_cycle();
		if (model_valid[a0]) begin
			check_value("data_out_0", data_out_0, model_mem[a0]);
		end
		if (model_valid[a1]) begin
			check_value("data_out_1", data_out_1, model_mem[a1]);
		end
	endtask

	// --------------------------------------
	// directed tests
	// --------------------------------------
	task automatic test_reset_state();
		logic [DW-1:0] d0;
		logic [DW-1:0] d1;
		apply_reset(1);
		d0 = $urandom() | DW'(1);    // nonzero words on both outputs
		d1 = $urandom() | DW'(1);
		write_pair(0, 1, d0, d1);
		read_pair(0, 1);
		advance_frame();    // frame_num away from 0
		apply_reset(1);
		check_value("frame_num", DW'(frame_num), '0);
		check_value("data_out_0", data_out_0, '0);
		check_value("data_out_1", data_out_1, '0);
		finish_test("reset_state");
	endtask

	task automatic test_dual_port();
		logic [DW-1:0] d0;
		logic [DW-1:0] d1;
		apply_reset(2);
		d0 = $urandom();
		d1 = $urandom();
		write_pair(5, 40, d0, d1);
		read_pair(5, 40);
		check_value("data_out_0", data_out_0, d0);
		check_value("data_out_1", data_out_1, d1);
		write_pair(12, 12, d1, d0);    // same address on both ports
		check_value("data_out_0", data_out_0, d0);    // held over the write
		check_value("data_out_1", data_out_1, d1);
		read_pair(12, 12);
		check_value("data_out_0", data_out_0, d1);
		check_value("data_out_1", data_out_1, d1);
		finish_test("dual_port");
	endtask

	task automatic test_history_recall();
		logic [DW-1:0] words [3];
		int            f;
		apply_reset(3);
		for (f = 0; f < 3; f++) begin
			words[f] = $urandom();
			write_pair(10, 20, words[f], ~words[f]);
			advance_frame();
		end
		read_pair(10, 20);    // frame 3 sees frame 0
		check_value("data_out_0", data_out_0, words[0]);
		advance_frame();
		read_pair(10, 20);    // frame 4 sees frame 1
		check_value("data_out_0", data_out_0, words[1]);
		finish_test("history_recall");
	endtask

	task automatic test_isolation();
		int n;
		int f;
		for (n = 1; n <= oflow_frame_pkg::MAX_HISTORY; n++) begin
			apply_reset(n);
			for (f = 0; f < n; f++) begin
				write_pair(3, 17, $urandom(), $urandom());
				advance_frame();
			end
			for (f = 0; f < n; f++) begin
				read_pair(3, 17);    // each slot only its own words
				advance_frame();
			end
		end
		finish_test("isolation");
	endtask

	task automatic test_clamp();
		logic [DW-1:0] prev;
		int            k;
		int            f;
		for (k = 0; k < 2; k++) begin
			apply_reset((k == 0) ? 0 : 7);
			prev = $urandom();
			write_pair(7, 9, prev, ~prev);
			for (f = 0; f < 3; f++) begin
				advance_frame();
				read_pair(7, 9);    // single region holds last frame's word
				check_value("data_out_0", data_out_0, prev);
				prev = $urandom();
				write_pair(7, 9, prev, ~prev);
			end
		end
		finish_test("clamp");
	endtask

	task automatic test_frame_wrap();
		logic [DW-1:0] word;
		int            f;
		apply_reset(2);
		for (f = 0; f < 253; f++) begin
			advance_frame();
		end
		num_of_history_frames = HW'(4);    // pending until the wrap
		word = $urandom();
		write_pair(30, 31, word, ~word);    // frame 253 under the old n
		advance_frame();
		advance_frame();
		read_pair(30, 31);
		check_value("data_out_0", data_out_0, word);
		advance_frame();    // 256th strobe
		check_value("frame_num", DW'(frame_num), '0);
		advance_frame();
		word = $urandom();
		write_pair(30, 31, word, ~word);    // frame 1 under the new n
		for (f = 0; f < 4; f++) begin
			advance_frame();
		end
		read_pair(30, 31);
		check_value("data_out_0", data_out_0, word);
		finish_test("frame_wrap");
	endtask

	// --------------------------------------
	// main sequence
	// --------------------------------------
	initial begin
		void'($urandom(32'h1683));
		clk = 1'b0;
		reset_N = 1'b0;
		frame_start = 1'b0;
		num_of_history_frames = HW'(1);
		we = 1'b0;
		offset_0 = '0;
		offset_1 = '0;
		data_in_0 = '0;
		data_in_1 = '0;
		err_count = 0;
		test_err_start = 0;
		tests_ok = 0;
		tests_bad = 0;
		mdl_frame = 0;
		mdl_n = 1;
		test_reset_state();
		test_dual_port();
		test_history_recall();
		test_isolation();
		test_clamp();
		test_frame_wrap();
		$display("summary: %0d tests ok, %0d tests with errors, %0d check errors",
			tests_ok, tests_bad, err_count);
		if (err_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule : oflow_buffer_tb

`default_nettype wire

/* hdl/all_mem.sv */
/*
 * Two-port synchronous RAM with active-low controls per port.
 * Write when csb and web are low, registered read when web is high.
 */
`default_nettype none

module all_mem #(
	parameter int DATA_WIDTH_MEM = oflow_mem_pkg::DATA_WIDTH_DEF,
	parameter int MEM_DEPTH = oflow_mem_pkg::MEM_DEPTH_DEF,
	parameter int ADDR_WIDTH = oflow_mem_pkg::ADDR_WIDTH_DEF
) (
	input  logic                      clk,
	input  logic                      reset_N,
	input  logic [ADDR_WIDTH-1:0]     address_0,
	input  logic [ADDR_WIDTH-1:0]     address_1,
	input  logic [DATA_WIDTH_MEM-1:0] data_in_0,
	input  logic [DATA_WIDTH_MEM-1:0] data_in_1,
	input  logic                      csb_0,      // chip select, active low
	input  logic                      csb_1,
	input  logic                      web_0,      // 0 = write, 1 = read
	input  logic                      web_1,
	input  logic                      oeb_0,      // output enable, active low
	input  logic                      oeb_1,
	output logic [DATA_WIDTH_MEM-1:0] data_out_0,
	output logic [DATA_WIDTH_MEM-1:0] data_out_1
);

	// --------------------------------------
	// storage and port strobes
	// --------------------------------------
	logic [DATA_WIDTH_MEM-1:0] mem [MEM_DEPTH];

	logic wr_0;
	logic wr_1;
	logic rd_0;
	logic rd_1;

	assign wr_0 = !csb_0 && !web_0;
	assign wr_1 = !csb_1 && !web_1;
	assign rd_0 = !csb_0 && web_0 && !oeb_0;    // output reg loads only when enabled
	assign rd_1 = !csb_1 && web_1 && !oeb_1;

	// --------------------------------------
	// write side
	// --------------------------------------
	// port 1 first so port 0 overwrites it on the same address
	always_ff @(posedge clk) begin
		if (wr_1) begin
			mem[address_1] <= data_in_1;
		end
		if (wr_0) begin
			mem[address_0] <= data_in_0;    // port 0 priority
		end
	end

	// --------------------------------------
	// read side, one cycle latency
	// --------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			data_out_0 <= '0;
			data_out_1 <= '0;
		end else begin
			if (rd_0) begin
				data_out_0 <= mem[address_0];    // holds during a write
			end
			if (rd_1) begin
				data_out_1 <= mem[address_1];
			end
		end
	end

endmodule : all_mem

`default_nettype wire

/* hdl/oflow_buffer_top.sv */
/*
 * Top of the history frame memory.
 * Connects the frame tracker to the region-addressed buffer and sets the geometry.
 */
`default_nettype none

module oflow_buffer_top #(
	parameter int DATA_WIDTH = oflow_mem_pkg::DATA_WIDTH_DEF,
	parameter int MEM_DEPTH = oflow_mem_pkg::MEM_DEPTH_DEF,
	parameter int ADDR_WIDTH = oflow_mem_pkg::ADDR_WIDTH_DEF
) (
	input  logic                                       clk,
	input  logic                                       reset_N,
	input  logic                                       frame_start,
	input  logic [oflow_frame_pkg::HIST_WIDTH-1:0]      num_of_history_frames,
	input  logic                                       we,
	input  logic [oflow_mem_pkg::OFFSET_WIDTH_DEF-1:0]  offset_0,
	input  logic [oflow_mem_pkg::OFFSET_WIDTH_DEF-1:0]  offset_1,
	input  logic [DATA_WIDTH-1:0]                      data_in_0,
	input  logic [DATA_WIDTH-1:0]                      data_in_1,
	output logic [oflow_frame_pkg::FRAME_NUM_WIDTH-1:0] frame_num,
	output logic [DATA_WIDTH-1:0]                      data_out_0,
	output logic [DATA_WIDTH-1:0]                      data_out_1
);

	// --------------------------------------
	// tracker to buffer
	// --------------------------------------
	logic [oflow_frame_pkg::SLOT_WIDTH-1:0] slot;          // current region index
	logic [oflow_frame_pkg::HIST_WIDTH-1:0] hist_count;    // latched n

	oflow_frame_tracker u_tracker (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_start           (frame_start),
		.num_of_history_frames (num_of_history_frames),
		.frame_num             (frame_num),
		.slot                  (slot),
		.hist_count            (hist_count)
	);

	oflow_mem_buffer #(
		.DATA_WIDTH (DATA_WIDTH),
		.MEM_DEPTH  (MEM_DEPTH),
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_buffer (
		.clk        (clk),
		.reset_N    (reset_N),
		.hist_count (hist_count),
		.slot       (slot),
		.offset_0   (offset_0),
		.offset_1   (offset_1),
		.we         (we),
		.data_in_0  (data_in_0),
		.data_in_1  (data_in_1),
		.data_out_0 (data_out_0),
		.data_out_1 (data_out_1)
	);

endmodule : oflow_buffer_top

`default_nettype wire

/* hdl/oflow_frame_pkg.sv */
/*
 * Frame counting and history limits.
 * Shared by the frame tracker, the memory buffer and the top level.
 */
`default_nettype none

package oflow_frame_pkg;

	// --------------------------------------
	// frame counter
	// --------------------------------------
	localparam int FRAME_NUM_WIDTH = 8;     // frames 0..255, then wrap

	// --------------------------------------
	// history frames
	// --------------------------------------
	localparam int HIST_WIDTH = 3;          // num_of_history_frames width
	localparam int MAX_HISTORY = 5;         // anything above this clamps to 1

	// slot = frame number mod n, so 0..MAX_HISTORY-1
	localparam int SLOT_WIDTH = 3;

endpackage : oflow_frame_pkg

`default_nettype wire

/* hdl/oflow_frame_tracker.sv */
/*
 * Frame tracker: counts frames on frame_start and keeps slot = frame_num mod n.
 * n is clamped to 1..5 and latched only at reset and at the frame wrap.
 */
`default_nettype none

module oflow_frame_tracker (
	input  logic                                       clk,
	input  logic                                       reset_N,
	input  logic                                       frame_start,    // one-cycle strobe
	input  logic [oflow_frame_pkg::HIST_WIDTH-1:0]      num_of_history_frames,
	output logic [oflow_frame_pkg::FRAME_NUM_WIDTH-1:0] frame_num,
	output logic [oflow_frame_pkg::SLOT_WIDTH-1:0]      slot,
	output logic [oflow_frame_pkg::HIST_WIDTH-1:0]      hist_count      // latched n
);

	// --------------------------------------
	// local signals
	// --------------------------------------
	logic [oflow_frame_pkg::HIST_WIDTH-1:0] hist_clamped;
	logic [oflow_frame_pkg::SLOT_WIDTH-1:0] slot_inc;
	logic                                   frame_wrap;
	logic                                   slot_wrap;

	// --------------------------------------
	// history count clamp
	// --------------------------------------
	// 0 and anything above MAX_HISTORY fall back to a single region
	always_comb begin
		hist_clamped = num_of_history_frames;
		if (num_of_history_frames == '0) begin
			hist_clamped = oflow_frame_pkg::HIST_WIDTH'(1);
		end else if (num_of_history_frames >
			oflow_frame_pkg::HIST_WIDTH'(oflow_frame_pkg::MAX_HISTORY)) begin
			hist_clamped = oflow_frame_pkg::HIST_WIDTH'(1);
		end
	end

	// --------------------------------------
	// wrap detection
	// --------------------------------------
	assign frame_wrap = (frame_num == '1);    // 255 -> 0 on next strobe
	assign slot_inc = slot + oflow_frame_pkg::SLOT_WIDTH'(1);
	// slot counts 0..n-1, no modulo needed
	assign slot_wrap = (slot_inc == oflow_frame_pkg::SLOT_WIDTH'(hist_count));

	// --------------------------------------
	// frame counter
	// --------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			frame_num <= '0;
		end else if (frame_start) begin
			frame_num <= frame_num + 1'b1;    // wraps naturally at 255
		end
	end

	// --------------------------------------
	// slot register
	// --------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			slot <= '0;
		end else if (frame_start) begin
			if (frame_wrap || slot_wrap) begin
				slot <= '0;    // frame 0 always lands in region 0
			end else begin
				slot <= slot_inc;
			end
		end
	end

	// --------------------------------------
	// latched history count
	// --------------------------------------
	// regions stay put for a whole 256-frame sequence
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			hist_count <= hist_clamped;
		end else if (frame_start && frame_wrap) begin
			hist_count <= hist_clamped;    // new n from frame 0
		end
	end

endmodule : oflow_frame_tracker

`default_nettype wire

/* hdl/oflow_mem_buffer.sv */
/*
 * History frame buffer: maps (slot, offset) onto one region of the shared RAM.
 * Region size is MEM_DEPTH / n rounded down, base is slot times region size.
 */
`default_nettype none

module oflow_mem_buffer #(
	parameter int DATA_WIDTH = oflow_mem_pkg::DATA_WIDTH_DEF,
	parameter int MEM_DEPTH = oflow_mem_pkg::MEM_DEPTH_DEF,
	parameter int ADDR_WIDTH = oflow_mem_pkg::ADDR_WIDTH_DEF
) (
	input  logic                                         clk,
	input  logic                                         reset_N,
	input  logic [oflow_frame_pkg::HIST_WIDTH-1:0]        hist_count,
	input  logic [oflow_frame_pkg::SLOT_WIDTH-1:0]        slot,
	input  logic [oflow_mem_pkg::OFFSET_WIDTH_DEF-1:0]    offset_0,
	input  logic [oflow_mem_pkg::OFFSET_WIDTH_DEF-1:0]    offset_1,
	input  logic                                         we,    // both ports together
	input  logic [DATA_WIDTH-1:0]                        data_in_0,
	input  logic [DATA_WIDTH-1:0]                        data_in_1,
	output logic [DATA_WIDTH-1:0]                        data_out_0,
	output logic [DATA_WIDTH-1:0]                        data_out_1
);

	// region size needs one extra bit, n = 1 gives the full depth
	localparam int REG_W = ADDR_WIDTH + 1;
	localparam int BASE_W = REG_W + oflow_frame_pkg::SLOT_WIDTH;

	// --------------------------------------
	// local signals
	// --------------------------------------
	logic [REG_W-1:0]      region_size;
	logic [BASE_W-1:0]     base_full;
	logic [ADDR_WIDTH-1:0] region_base;
	logic [ADDR_WIDTH-1:0] addr_0;
	logic [ADDR_WIDTH-1:0] addr_1;
	logic                  web;

	// --------------------------------------
	// region size per history count
	// --------------------------------------
	// constant divisions only, no divider in hardware
	always_comb begin
		case (hist_count)
			1:       region_size = REG_W'(MEM_DEPTH);
			2:       region_size = REG_W'(MEM_DEPTH / 2);    // 64
			3:       region_size = REG_W'(MEM_DEPTH / 3);    // 42, 2 words unused
			4:       region_size = REG_W'(MEM_DEPTH / 4);    // 32
			5:       region_size = REG_W'(MEM_DEPTH / 5);    // 25
			default: region_size = REG_W'(MEM_DEPTH);        // tracker never gives this
		endcase
	end

	// --------------------------------------
	// address generation
	// --------------------------------------
	assign base_full = BASE_W'(region_size) * BASE_W'(slot);
	// slot < n keeps the base inside the RAM
	assign region_base = base_full[ADDR_WIDTH-1:0];

	assign addr_0 = region_base + ADDR_WIDTH'(offset_0);    // offset must be < region size
	assign addr_1 = region_base + ADDR_WIDTH'(offset_1);

	assign web = ~we;    // RAM write enable is active low

	// --------------------------------------
	// RAM
	// --------------------------------------
	all_mem #(
		.DATA_WIDTH_MEM (DATA_WIDTH),
		.MEM_DEPTH      (MEM_DEPTH),
		.ADDR_WIDTH     (ADDR_WIDTH)
	) u_all_mem (
		.clk        (clk),
		.reset_N    (reset_N),
		.address_0  (addr_0),
		.address_1  (addr_1),
		.data_in_0  (data_in_0),
		.data_in_1  (data_in_1),
		.csb_0      (1'b0),    // always selected
		.csb_1      (1'b0),
		.web_0      (web),
		.web_1      (web),
		.oeb_0      (1'b0),    // outputs always enabled
		.oeb_1      (1'b0),
		.data_out_0 (data_out_0),
		.data_out_1 (data_out_1)
	);

endmodule : oflow_mem_buffer

`default_nettype wire

/* hdl/oflow_mem_pkg.sv */
/*
 * Memory geometry for the history frame buffer.
 * Default width, depth and address sizes of the shared RAM, referenced by scoped name.
 */
`default_nettype none

package oflow_mem_pkg;

	// --------------------------------------
	// pixel word
	// --------------------------------------
	localparam int DATA_WIDTH_DEF = 32;     // one pixel word per RAM entry

	// --------------------------------------
	// RAM geometry
	// --------------------------------------
	localparam int MEM_DEPTH_DEF = 128;     // words, split over all history regions

	// enough bits for MEM_DEPTH_DEF words
	localparam int ADDR_WIDTH_DEF = 7;

	// offset inside one region
	// widest region is the whole RAM (n = 1)
	localparam int OFFSET_WIDTH_DEF = 7;

endpackage : oflow_mem_pkg

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile and run the history buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module oflow_buffer_tb -f sources.f \
	-Mdir obj_dir -o oflow_buffer_sim

./obj_dir/oflow_buffer_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "test failed" "$LOG"; then
	exit 1
fi
exit 0

/* sources.f */
hdl/oflow_mem_pkg.sv
hdl/oflow_frame_pkg.sv
hdl/all_mem.sv
hdl/oflow_frame_tracker.sv
hdl/oflow_mem_buffer.sv
hdl/oflow_buffer_top.sv
bench/oflow_buffer_props.sv
bench/oflow_buffer_tb.sv
